//--- verilog/mv_pkg.sv
package mv_pkg;

    // Matrix element and weight width
    localparam int DATA_WIDTH = 8;

    // Partial sum and result width
    localparam int PSUM_WIDTH = 32;

    // One matrix element or one weight
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Full-precision product of two data values
    typedef logic [2*DATA_WIDTH-1:0] prod_t;

    // One partial sum or one result element
    typedef logic [PSUM_WIDTH-1:0] psum_t;

endpackage

//--- verilog/pe.sv
module pe (
    input  logic          clk,
    input  logic          rst_n,

    // Data in
    input  mv_pkg::data_t weight_i,
    input  mv_pkg::data_t ifmap_i,
    input  mv_pkg::psum_t psum_i,

    // Enables in
    input  logic          weight_en_i,
    input  logic          ifmap_en_i,
    input  logic          psum_en_i,

    // Data out
    output mv_pkg::data_t weight_o,
    output mv_pkg::data_t ifmap_o,
    output mv_pkg::psum_t psum_o,

    // Enables out, one cycle behind the inputs
    output logic          weight_en_o,
    output logic          psum_en_o
);

    import mv_pkg::*;

    data_t weight_q;
    data_t ifmap_q;
    psum_t psum_q;
    prod_t product_q;
    logic  weight_en_q;
    logic  psum_en_q;

    // Enables move one element per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_en_q <= 1'b0;
            psum_en_q   <= 1'b0;
        end else begin
            weight_en_q <= weight_en_i;
            psum_en_q   <= psum_en_i;
        end
    end

    // Weight forwarded to the right neighbour
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_q <= '0;
        end else if (weight_en_i) begin
            weight_q <= weight_i;
        end
    end

    // Stationary matrix element
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_q <= '0;
        end else if (ifmap_en_i) begin
            ifmap_q <= ifmap_i;
        end
    end

    // Partial sum arriving from above
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_q <= '0;
        end else if (psum_en_i) begin
            psum_q <= psum_i;
        end
    end

    // Product stage, lines up with the registered partial sum
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            product_q <= '0;
        end else if (weight_en_i) begin
            product_q <= ifmap_q * weight_i;
        end
    end

    // Valid while psum_en_o is high
    assign psum_o      = psum_q + psum_t'(product_q);

    assign weight_o    = weight_q;
    assign ifmap_o     = ifmap_q;
    assign weight_en_o = weight_en_q;
    assign psum_en_o   = psum_en_q;

endmodule

//--- verilog/skew_feeder.sv
module skew_feeder #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Vector strobe and its ROWS weights
    input  logic                              vec_valid_i,
    input  logic [ROWS*mv_pkg::DATA_WIDTH-1:0] vec_i,

    // Skewed weights into the left edge of the array
    output logic [ROWS*mv_pkg::DATA_WIDTH-1:0] row_weight_o,
    output logic [ROWS-1:0]                   row_weight_en_o,

    // Partial-sum starts into the top edge of the array
    output logic [COLS-1:0]                   col_psum_en_o
);

    import mv_pkg::*;

    // Long enough to serve both the row and the column taps
    localparam int EN_DEPTH = (ROWS > COLS) ? ROWS : COLS;

    logic [EN_DEPTH-1:0] en_q;

    // Single strobe chain, tap k fires k cycles after the first register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= '0;
        end else begin
            en_q[0] <= vec_valid_i;
            for (int k = 1; k < EN_DEPTH; k++) begin
                en_q[k] <= en_q[k-1];
            end
        end
    end

    assign row_weight_en_o = en_q[ROWS-1:0];
    assign col_psum_en_o   = en_q[COLS-1:0];

    // Triangular delay line, row r has r+1 stages
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        data_t dly_q [r+1];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int k = 0; k <= r; k++) begin
                    dly_q[k] <= '0;
                end
            end else begin
                // First stage captures the vector on its strobe
                if (vec_valid_i) begin
                    dly_q[0] <= vec_i[r*DATA_WIDTH +: DATA_WIDTH];
                end
                for (int k = 1; k <= r; k++) begin
                    dly_q[k] <= dly_q[k-1];
                end
            end
        end

        assign row_weight_o[r*DATA_WIDTH +: DATA_WIDTH] = dly_q[r];
    end

endmodule

//--- verilog/pe_array.sv
module pe_array #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // Left edge, one weight per row
    input  logic [ROWS*mv_pkg::DATA_WIDTH-1:0]     row_weight_i,
    input  logic [ROWS-1:0]                       row_weight_en_i,

    // Top edge, one partial-sum start per column
    input  logic [COLS-1:0]                       col_psum_en_i,

    // Matrix row load
    input  logic                                  load_i,
    input  logic [$clog2(ROWS > 1 ? ROWS : 2)-1:0] load_row_i,
    input  logic [COLS*mv_pkg::DATA_WIDTH-1:0]     load_data_i,

    // Bottom edge, one column sum per column
    output logic [COLS*mv_pkg::PSUM_WIDTH-1:0]     col_psum_o,
    output logic [COLS-1:0]                       col_psum_valid_o
);

    import mv_pkg::*;

    // Horizontal chains, index c is the input of column c
    data_t w_chain   [ROWS][COLS+1];
    logic  we_chain  [ROWS][COLS+1];

    // Vertical chains, index r is the input of row r
    psum_t ps_chain  [ROWS+1][COLS];
    logic  pse_chain [ROWS+1][COLS];

    logic [ROWS-1:0] row_load;

    // Row select for matrix loading
    for (genvar r = 0; r < ROWS; r++) begin : g_load
        assign row_load[r] = load_i && (load_row_i == r);
    end

    // Left edge feed
    for (genvar r = 0; r < ROWS; r++) begin : g_left
        assign w_chain[r][0]  = row_weight_i[r*DATA_WIDTH +: DATA_WIDTH];
        assign we_chain[r][0] = row_weight_en_i[r];
    end

    // Top row starts from zero, bottom row leaves the array
    for (genvar c = 0; c < COLS; c++) begin : g_edge
        assign ps_chain[0][c]  = '0;
        assign pse_chain[0][c] = col_psum_en_i[c];

        assign col_psum_o[c*PSUM_WIDTH +: PSUM_WIDTH] = ps_chain[ROWS][c];
        assign col_psum_valid_o[c]                    = pse_chain[ROWS][c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            pe pe_i (
                .clk         (clk),
                .rst_n       (rst_n),
                .weight_i    (w_chain[r][c]),
                .ifmap_i     (load_data_i[c*DATA_WIDTH +: DATA_WIDTH]),
                .psum_i      (ps_chain[r][c]),
                .weight_en_i (we_chain[r][c]),
                .ifmap_en_i  (row_load[r]),
                .psum_en_i   (pse_chain[r][c]),
                .weight_o    (w_chain[r][c+1]),
                .ifmap_o     (),
                .psum_o      (ps_chain[r+1][c]),
                .weight_en_o (we_chain[r][c+1]),
                .psum_en_o   (pse_chain[r+1][c])
            );
        end
    end

endmodule

//--- verilog/deskew_collector.sv
module deskew_collector #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Column sums, column c arrives c cycles after column 0
    input  logic [COLS*mv_pkg::PSUM_WIDTH-1:0] col_psum_i,
    input  logic [COLS-1:0]                   col_psum_valid_i,

    // Aligned result vector
    output logic [COLS*mv_pkg::PSUM_WIDTH-1:0] result_o,
    output logic                              result_valid_o
);

    import mv_pkg::*;

    psum_t aligned [COLS];
    logic  aligned_vld;

    // Column c waits COLS-1-c cycles
    for (genvar c = 0; c < COLS; c++) begin : g_col
        localparam int D = COLS - 1 - c;

        if (D == 0) begin : g_direct
            assign aligned[c] = col_psum_i[c*PSUM_WIDTH +: PSUM_WIDTH];
        end else begin : g_delay
            psum_t dly_q [D];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int k = 0; k < D; k++) begin
                        dly_q[k] <= '0;
                    end
                end else begin
                    // Hold the sum from its valid cycle onward
                    if (col_psum_valid_i[c]) begin
                        dly_q[0] <= col_psum_i[c*PSUM_WIDTH +: PSUM_WIDTH];
                    end
                    for (int k = 1; k < D; k++) begin
                        dly_q[k] <= dly_q[k-1];
                    end
                end
            end

            assign aligned[c] = dly_q[D-1];
        end
    end

    // Column 0 valid delayed to the common alignment point
    if (COLS == 1) begin : g_vld_direct
        assign aligned_vld = col_psum_valid_i[0];
    end else begin : g_vld_delay
        logic [COLS-2:0] vld_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= col_psum_valid_i[0];
                for (int k = 1; k < COLS - 1; k++) begin
                    vld_q[k] <= vld_q[k-1];
                end
            end
        end

        assign aligned_vld = vld_q[COLS-2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= aligned_vld;
            // All columns line up with column 0's delayed valid
            if (aligned_vld) begin
                for (int c = 0; c < COLS; c++) begin
                    result_o[c*PSUM_WIDTH +: PSUM_WIDTH] <= aligned[c];
                end
            end
        end
    end

endmodule

//--- verilog/systolic_mv.sv
module systolic_mv #(
    parameter int ROWS = 4,
    parameter int COLS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // Input vector
    input  logic                                  vec_valid_i,
    input  logic [ROWS*mv_pkg::DATA_WIDTH-1:0]     vec_i,

    // Matrix row load
    input  logic                                  load_i,
    input  logic [$clog2(ROWS > 1 ? ROWS : 2)-1:0] load_row_i,
    input  logic [COLS*mv_pkg::DATA_WIDTH-1:0]     load_data_i,

    // Result vector, ROWS+COLS+1 cycles after the strobe
    output logic                                  result_valid_o,
    output logic [COLS*mv_pkg::PSUM_WIDTH-1:0]     result_o
);

    import mv_pkg::*;

    data_t [ROWS-1:0] row_weight;
    logic  [ROWS-1:0] row_weight_en;
    logic  [COLS-1:0] col_psum_en;
    psum_t [COLS-1:0] col_psum;
    logic  [COLS-1:0] col_psum_valid;

    skew_feeder #(.ROWS(ROWS), .COLS(COLS)) feeder_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .vec_valid_i     (vec_valid_i),
        .vec_i           (vec_i),
        .row_weight_o    (row_weight),
        .row_weight_en_o (row_weight_en),
        .col_psum_en_o   (col_psum_en)
    );

    pe_array #(.ROWS(ROWS), .COLS(COLS)) array_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .row_weight_i     (row_weight),
        .row_weight_en_i  (row_weight_en),
        .col_psum_en_i    (col_psum_en),
        .load_i           (load_i),
        .load_row_i       (load_row_i),
        .load_data_i      (load_data_i),
        .col_psum_o       (col_psum),
        .col_psum_valid_o (col_psum_valid)
    );

    deskew_collector #(.ROWS(ROWS), .COLS(COLS)) collector_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .col_psum_i       (col_psum),
        .col_psum_valid_i (col_psum_valid),
        .result_o         (result_o),
        .result_valid_o   (result_valid_o)
    );

endmodule

//--- bench/tb_systolic_mv.sv
module tb_systolic_mv;

    timeunit 1ns;
    timeprecision 100ps;

    import mv_pkg::*;

    localparam int ROWS         = 4;
    localparam int COLS         = 4;
    localparam int ROW_W        = $clog2(ROWS);
    localparam int LATENCY      = ROWS + COLS + 1;
    localparam int RESET_CYCLES = 8;
    localparam int N_PIPE       = 20;
    localparam int N_IRREG      = 30;
    localparam int MAX_GAP      = 3;
    // Drain of one test: latency plus the two idle cycles after it
    localparam int DRAIN        = LATENCY + 3;
    localparam int STIM_CYCLES  = RESET_CYCLES + 11 + (ROWS + 1) + N_PIPE
                                + N_IRREG * (MAX_GAP + 1) + (ROWS + 4)
                                + (2 * ROWS + 2) + 7 * DRAIN;
    localparam int MAX_CYCLES   = STIM_CYCLES + 50;

    logic                        clk;
    logic                        rst_n;
    logic                        vec_valid_i;
    logic [ROWS*DATA_WIDTH-1:0]  vec_i;
    logic                        load_i;
    logic [ROW_W-1:0]            load_row_i;
    logic [COLS*DATA_WIDTH-1:0]  load_data_i;
    logic                        result_valid_o;
    logic [COLS*PSUM_WIDTH-1:0]  result_o;

    // Reference copy of the stationary matrix
    data_t mat [ROWS][COLS];

    // Outstanding results, oldest first
    logic [COLS*PSUM_WIDTH-1:0] exp_q [$];
    int unsigned                due_q [$];
    string                      name_q [$];

    int unsigned cycle;
    int          errors;
    int          checks;
    integer      seed;

    systolic_mv #(.ROWS(ROWS), .COLS(COLS)) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .vec_valid_i    (vec_valid_i),
        .vec_i          (vec_i),
        .load_i         (load_i),
        .load_row_i     (load_row_i),
        .load_data_i    (load_data_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // y[c] is the sum over r of X[r][c] * w[r]
    function automatic logic [COLS*PSUM_WIDTH-1:0] model_result(
        input logic [ROWS*DATA_WIDTH-1:0] vec
    );
        logic [COLS*PSUM_WIDTH-1:0] res;
        psum_t                      acc;
        res = '0;
        for (int c = 0; c < COLS; c++) begin
            acc = '0;
            for (int r = 0; r < ROWS; r++) begin
                acc = acc + psum_t'(mat[r][c]) * psum_t'(vec[r*DATA_WIDTH +: DATA_WIDTH]);
            end
            res[c*PSUM_WIDTH +: PSUM_WIDTH] = acc;
        end
        return res;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_vector(input logic [ROWS*DATA_WIDTH-1:0] vec, input string name);
        exp_q.push_back(model_result(vec));
        due_q.push_back(cycle + LATENCY);
        name_q.push_back(name);
        vec_valid_i = 1'b1;
        vec_i       = vec;
        idle(1);
        vec_valid_i = 1'b0;
    endtask

    task automatic load_row(input int row, input logic [COLS*DATA_WIDTH-1:0] data);
        for (int c = 0; c < COLS; c++) begin
            mat[row][c] = data[c*DATA_WIDTH +: DATA_WIDTH];
        end
        load_i      = 1'b1;
        load_row_i  = ROW_W'(row);
        load_data_i = data;
        idle(1);
        load_i      = 1'b0;
    endtask

    task automatic random_vec(output logic [ROWS*DATA_WIDTH-1:0] vec);
        for (int r = 0; r < ROWS; r++) begin
            vec[r*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'($random(seed));
        end
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    task automatic check_result();
        logic [COLS*PSUM_WIDTH-1:0] exp;
        int unsigned                due;
        string                      name;
        exp  = exp_q.pop_front();
        due  = due_q.pop_front();
        name = name_q.pop_front();
        checks++;
        latency_exact: assert (due == cycle) else begin
            $display("ERROR: %s result arrived at cycle %0d but was due at cycle %0d",
                     name, cycle, due);
            errors++;
        end
        for (int c = 0; c < COLS; c++) begin
            result_match: assert (result_o[c*PSUM_WIDTH +: PSUM_WIDTH]
                                  == exp[c*PSUM_WIDTH +: PSUM_WIDTH]) else begin
                $display("FAILED %s col %0d expected %0d actual %0d", name, c,
                         exp[c*PSUM_WIDTH +: PSUM_WIDTH],
                         result_o[c*PSUM_WIDTH +: PSUM_WIDTH]);
                errors++;
            end
        end
    endtask

    // No result may leave while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !result_valid_o) else begin
        $display("ERROR: result_valid_o high during reset");
        errors++;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("ERROR: timeout after %0d cycles with %0d results outstanding",
                     cycle, exp_q.size());
            errors++;
            finish_run();
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (result_valid_o) begin
                pulse_expected: assert (exp_q.size() != 0) else begin
                    $display("ERROR: result pulse at cycle %0d with no vector outstanding",
                             cycle);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    check_result();
                end
            end else if (due_q.size() != 0) begin
                pulse_on_time: assert (due_q[0] > cycle) else begin
                    $display("ERROR: %s result missing, no pulse at cycle %0d",
                             name_q[0], due_q[0]);
                    errors++;
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                    void'(name_q.pop_front());
                end
            end
        end
    end

    initial begin
        logic [ROWS*DATA_WIDTH-1:0] vec;
        int                         gap;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h13a6;
        rst_n       = 1'b0;
        vec_valid_i = 1'b0;
        vec_i       = '0;
        load_i      = 1'b0;
        load_row_i  = '0;
        load_data_i = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                mat[r][c] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet after reset, empty matrix gives zeros
        repeat (10) begin
            @(negedge clk);
            idle_quiet: assert (!result_valid_o) else begin
                $display("ERROR: result_valid_o high while idle after reset");
                errors++;
            end
        end
        idle(1);
        send_vector({8'd9, 8'd7, 8'd5, 8'd3}, "reset_zero");
        wait_idle();

        // Known matrix, one vector
        for (int r = 0; r < ROWS; r++) begin
            load_row(r, {8'(r*COLS + 4), 8'(r*COLS + 3), 8'(r*COLS + 2), 8'(r*COLS + 1)});
        end
        send_vector({8'd4, 8'd3, 8'd2, 8'd1}, "single_product");
        wait_idle();

        // Back to back vectors
        for (int i = 0; i < N_PIPE; i++) begin
            random_vec(vec);
            send_vector(vec, "pipelining");
        end
        wait_idle();

        // Random gaps between strobes
        for (int i = 0; i < N_IRREG; i++) begin
            random_vec(vec);
            send_vector(vec, "irregular");
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            idle(gap);
        end
        wait_idle();

        // Largest operands, 4*255*255 per column
        for (int r = 0; r < ROWS; r++) begin
            load_row(r, '1);
        end
        repeat (4) begin
            send_vector('1, "full_scale");
        end
        wait_idle();

        // Same vector before and after a row reload
        for (int r = 0; r < ROWS; r++) begin
            random_vec(vec);
            load_row(r, vec);
        end
        random_vec(vec);
        send_vector(vec, "reload_before");
        wait_idle();
        load_row(2, {8'd17, 8'd200, 8'd0, 8'd99});
        send_vector(vec, "reload_after");
        wait_idle();

        finish_run();
    end

endmodule

//--- systolic_mv.f
verilog/mv_pkg.sv
verilog/pe.sv
verilog/skew_feeder.sv
verilog/pe_array.sv
verilog/deskew_collector.sv
verilog/systolic_mv.sv
bench/tb_systolic_mv.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the systolic_mv testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_systolic_mv \
    -f systolic_mv.f

./obj_dir/Vtb_systolic_mv > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi
